/* hw/mem_cfg_pkg.sv */
// ==============================
// memory geometry
// word and address widths, bank layout and address decode helpers
// ==============================
`default_nettype none

package mem_cfg_pkg;

  localparam int DATA_W   = 16;
  localparam int BIT_VROW = 4;
  localparam int NUM_VROW = 16;  // rows in each bank
  localparam int NUM_VBNK = 4;
  localparam int NUM_PBNK = 5;   // one spare bank on top of the virtual ones
  localparam int BIT_PBNK = 3;
  localparam int ADDR_W   = BIT_PBNK + BIT_VROW;

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [BIT_PBNK-1:0] bank_t;
  typedef logic [BIT_VROW-1:0] row_t;

  function automatic bank_t bank_of(addr_t a);
    return a[ADDR_W-1 -: BIT_PBNK];
  endfunction

  function automatic row_t row_of(addr_t a);
    return a[BIT_VROW-1:0];
  endfunction

  // access mode keeps the address space to the virtual banks only
  function automatic logic in_range(addr_t a, logic acc);
    return acc ? (int'(a) < NUM_VROW * NUM_VBNK) : (int'(a) < NUM_VROW * NUM_PBNK);
  endfunction

endpackage

`default_nettype wire

/* hw/mem_req_pkg.sv */
// ==============================
// request side types
// read port count and mask, Wishbone slave states
// ==============================
`default_nettype none

package mem_req_pkg;

  localparam int NUM_RDPT = 4;

  typedef logic [NUM_RDPT-1:0] port_mask_t;  // one bit per read port

  typedef enum logic {
    IDLE,
    RESP
  } wb_state_t;

endpackage

`default_nettype wire

/* hw/mem_rd_if.sv */
// ==============================
// granted read bundle
// guard to storage requests and the read data coming back
// ==============================
`default_nettype none

interface mem_rd_if;

  mem_req_pkg::port_mask_t grant;
  mem_cfg_pkg::addr_t      addr [mem_req_pkg::NUM_RDPT];
  mem_req_pkg::port_mask_t vld;   // one cycle after grant
  mem_cfg_pkg::data_t      data [mem_req_pkg::NUM_RDPT];

  modport guard (
    output grant,
    output addr,
    input  data
  );

  modport storage (
    input  grant,
    input  addr,
    output data,
    output vld
  );

endinterface

`default_nettype wire

/* hw/read_port_guard.sv */
// ==============================
// read port guard
// bank decode plus conflict and range arbitration for the four read
// ports, refused reads come back as err next cycle
// ==============================
`default_nettype none

module read_port_guard (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     rd_acc,
  input  wire mem_req_pkg::port_mask_t req,
  input  wire mem_cfg_pkg::addr_t addr [mem_req_pkg::NUM_RDPT],
  mem_rd_if.guard                 rd,
  output mem_req_pkg::port_mask_t err
);

  mem_cfg_pkg::bank_t      bank [mem_req_pkg::NUM_RDPT];
  mem_req_pkg::port_mask_t live;  // requested and in range
  mem_req_pkg::port_mask_t grant;

  always_comb begin
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
      bank[i] = mem_cfg_pkg::bank_of(addr[i]);
      live[i] = req[i] && mem_cfg_pkg::in_range(addr[i], rd_acc);
    end
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
      grant[i] = live[i] && (!rd_acc || i == 0);
      // lower port wins the bank
      for (int k = 0; k < i; k++) begin
        if (live[k] && bank[k] == bank[i]) grant[i] = 1'b0;
      end
    end
  end

  assign rd.grant = grant;
  assign rd.addr  = addr;

  // lines up with vld from the storage
  always_ff @(posedge clk) begin
    if (!rst_n) err <= '0;
    else        err <= req & ~grant;
  end

  // ==============================
  // checks on what reaches the banks

  for (genvar j = 1; j < mem_req_pkg::NUM_RDPT; j++) begin : g_conf
    for (genvar k = 0; k < j; k++) begin : g_pair
      a_bank_conflict: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd.grant[j] && rd.grant[k] &&
          mem_cfg_pkg::bank_of(rd.addr[j]) == mem_cfg_pkg::bank_of(rd.addr[k])))
        else $error("read bank conflict between ports %0d and %0d", j, k);
    end
  end

  a_rdacc_port0: assert property (@(posedge clk) disable iff (!rst_n)
    rd_acc |-> !(|rd.grant[mem_req_pkg::NUM_RDPT-1:1]))
    else $error("read port above 0 granted in access mode");

  for (genvar i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin : g_range
    a_range: assert property (@(posedge clk) disable iff (!rst_n)
      rd.grant[i] |-> mem_cfg_pkg::in_range(rd.addr[i], rd_acc))
      else $error("port %0d granted out of range address 0x%0h", i, rd.addr[i]);
  end

endmodule

`default_nettype wire

/* hw/bank_array.sv */
// ==============================
// banked storage
// flop banks with one write port, four granted reads and the
// Wishbone read path, all reads registered
// ==============================
`default_nettype none

module bank_array (
  input  wire                     clk,
  input  wire                     rst_n,
  mem_rd_if.storage               rd,
  input  wire                     wr_en,
  input  wire mem_cfg_pkg::addr_t wr_addr,
  input  wire mem_cfg_pkg::data_t wr_data,
  input  wire mem_cfg_pkg::addr_t wb_raddr,
  output mem_cfg_pkg::data_t      wb_rdata
);

  mem_cfg_pkg::data_t mem [mem_cfg_pkg::NUM_PBNK][mem_cfg_pkg::NUM_VROW];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[mem_cfg_pkg::bank_of(wr_addr)][mem_cfg_pkg::row_of(wr_addr)] <= wr_data;
    end
  end

  // a read in the same cycle as a write to its row gets the old word
  always_ff @(posedge clk) begin
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
      if (rd.grant[i]) begin
        rd.data[i] <= mem[mem_cfg_pkg::bank_of(rd.addr[i])][mem_cfg_pkg::row_of(rd.addr[i])];
      end
    end
    wb_rdata <= mem[mem_cfg_pkg::bank_of(wb_raddr)][mem_cfg_pkg::row_of(wb_raddr)];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) rd.vld <= '0;
    else        rd.vld <= rd.grant;
  end

  // ==============================
  // each physical bank serves a single read per cycle

  mem_req_pkg::port_mask_t bank_hit [mem_cfg_pkg::NUM_PBNK];

  always_comb begin
    for (int b = 0; b < mem_cfg_pkg::NUM_PBNK; b++) begin
      for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
        bank_hit[b][i] = rd.grant[i] && int'(mem_cfg_pkg::bank_of(rd.addr[i])) == b;
      end
    end
  end

  for (genvar b = 0; b < mem_cfg_pkg::NUM_PBNK; b++) begin : g_bank
    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
      $countones(bank_hit[b]) <= 1)
      else $error("bank %0d read by more than one port", b);
  end

endmodule

`default_nettype wire

/* hw/wb_rw_port.sv */
// ==============================
// Wishbone read-write port
// classic slave with range check and one response per request
// ==============================
`default_nettype none

module wb_rw_port (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     rd_acc,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire mem_cfg_pkg::addr_t wb_adr,
  input  wire mem_cfg_pkg::data_t wb_dat_w,
  output mem_cfg_pkg::data_t      wb_dat_r,
  output logic                    wb_ack,
  output logic                    wb_err,
  output logic                    wr_en,
  output mem_cfg_pkg::addr_t      wr_addr,
  output mem_cfg_pkg::data_t      wr_data,
  output mem_cfg_pkg::addr_t      mem_raddr,
  input  wire mem_cfg_pkg::data_t mem_rdata
);

  mem_req_pkg::wb_state_t state;
  logic                   req;
  logic                   ok;

  assign req = wb_cyc && wb_stb && state == mem_req_pkg::IDLE;
  assign ok  = mem_cfg_pkg::in_range(wb_adr, rd_acc);

  assign wr_en     = req && wb_we && ok;
  assign wr_addr   = wb_adr;
  assign wr_data   = wb_dat_w;
  assign mem_raddr = ok ? wb_adr : '0;
  assign wb_dat_r  = mem_rdata;  // the storage registers it so it is valid with ack

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= mem_req_pkg::IDLE;
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      case (state)
        mem_req_pkg::IDLE: begin
          if (req) begin
            wb_ack <= ok;
            wb_err <= !ok;
            state  <= mem_req_pkg::RESP;
          end
        end
        default: begin
          wb_ack <= 1'b0;
          wb_err <= 1'b0;
          if (!wb_stb) state <= mem_req_pkg::IDLE;  // keep waiting while the master holds stb
        end
      endcase
    end
  end

  a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack && wb_err))
    else $error("ack and err raised together");

endmodule

`default_nettype wire

/* hw/multiport_mem.sv */
// ==============================
// 4R1RW banked memory top
// four guarded read ports plus one Wishbone read-write port
// ==============================
`default_nettype none

module multiport_mem (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rd_acc,
  // read ports
  input  wire mem_req_pkg::port_mask_t rd_req,
  input  wire mem_cfg_pkg::addr_t      rd_addr [mem_req_pkg::NUM_RDPT],
  output mem_req_pkg::port_mask_t      rd_vld,
  output mem_req_pkg::port_mask_t      rd_err,
  output mem_cfg_pkg::data_t           rd_data [mem_req_pkg::NUM_RDPT],
  // Wishbone slave
  input  wire                          wb_cyc,
  input  wire                          wb_stb,
  input  wire                          wb_we,
  input  wire mem_cfg_pkg::addr_t      wb_adr,
  input  wire mem_cfg_pkg::data_t      wb_dat_w,
  output mem_cfg_pkg::data_t           wb_dat_r,
  output logic                         wb_ack,
  output logic                         wb_err
);

  logic               wr_en;
  mem_cfg_pkg::addr_t wr_addr;
  mem_cfg_pkg::data_t wr_data;
  mem_cfg_pkg::addr_t mem_raddr;
  mem_cfg_pkg::data_t mem_rdata;

  mem_rd_if rd_if ();

  read_port_guard u_guard (
    .clk    (clk),
    .rst_n  (rst_n),
    .rd_acc (rd_acc),
    .req    (rd_req),
    .addr   (rd_addr),
    .rd     (rd_if.guard),
    .err    (rd_err)
  );

  bank_array u_banks (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd       (rd_if.storage),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wb_raddr (mem_raddr),
    .wb_rdata (mem_rdata)
  );

  wb_rw_port u_wb (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_acc    (rd_acc),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata)
  );

  assign rd_vld  = rd_if.vld;
  assign rd_data = rd_if.data;

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// ==============================
// testbench clock and reset
// 100 unit clock, reset low for the first 10 cycles
// ==============================
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);  // release away from the active edge
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/tb_multiport_mem.sv */
// ==============================
// multiport memory testbench
// table of Wishbone and read port steps checked against a shadow copy
// ==============================
`default_nettype none

module tb_multiport_mem;

  localparam int TIMEOUT = 20;

  typedef enum logic [1:0] {OP_WB_WR, OP_WB_RD, OP_PT_RD} op_t;

  typedef struct packed {
    op_t                                              op;
    logic                                             acc;
    mem_cfg_pkg::addr_t [mem_req_pkg::NUM_RDPT-1:0]   addr;  // wb uses addr[0]
    mem_req_pkg::port_mask_t                          req;
    mem_req_pkg::port_mask_t                          err;   // wb err is bit 0
    logic [3:0]                                       hold;
  } step_t;

  logic clk;
  logic rst_n;
  logic rd_acc;
  mem_req_pkg::port_mask_t rd_req;
  mem_cfg_pkg::addr_t      rd_addr [mem_req_pkg::NUM_RDPT];
  mem_req_pkg::port_mask_t rd_vld;
  mem_req_pkg::port_mask_t rd_err;
  mem_cfg_pkg::data_t      rd_data [mem_req_pkg::NUM_RDPT];
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  mem_cfg_pkg::addr_t wb_adr;
  mem_cfg_pkg::data_t wb_dat_w;
  mem_cfg_pkg::data_t wb_dat_r;
  logic wb_ack;
  logic wb_err;

  mem_cfg_pkg::data_t shadow [2**mem_cfg_pkg::ADDR_W];
  logic [31:0]        lfsr;
  step_t              steps [$];

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  multiport_mem UUT (
    .clk(clk), .rst_n(rst_n), .rd_acc(rd_acc),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_vld(rd_vld), .rd_err(rd_err), .rd_data(rd_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_err(wb_err)
  );

  // ==============================
  // helpers

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input mem_cfg_pkg::data_t got, input mem_cfg_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mask(input mem_req_pkg::port_mask_t got,
                            input mem_req_pkg::port_mask_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic next_word(output mem_cfg_pkg::data_t w);
    w = '0;
    for (int b = 0; b < mem_cfg_pkg::DATA_W; b++) begin
      w    = {w[mem_cfg_pkg::DATA_W-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_step(input op_t op, input logic acc, input mem_cfg_pkg::addr_t a0,
                          input mem_cfg_pkg::addr_t a1, input mem_cfg_pkg::addr_t a2,
                          input mem_cfg_pkg::addr_t a3, input mem_req_pkg::port_mask_t req,
                          input mem_req_pkg::port_mask_t err, input logic [3:0] hold);
    step_t s;
    s.op   = op;
    s.acc  = acc;
    s.addr = {a3, a2, a1, a0};
    s.req  = req;
    s.err  = err;
    s.hold = hold;
    steps.push_back(s);
  endtask

  // rst_n moves on the falling edge so it is looked at on the rising one
  task automatic wait_reset();
    int n;
    n = 0;
    @(posedge clk);
    while (!rst_n) begin
      if (n == 4 * TIMEOUT) begin
        $display("reset was never released");
        abort_run();
      end
      n++;
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // ==============================
  // bus drivers

  task automatic wb_cycle(input logic we, input mem_cfg_pkg::addr_t a, input logic exp_err,
                          input int hold);
    mem_cfg_pkg::data_t wdata;
    int n;
    wdata = '0;
    if (we) next_word(wdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = a;
    wb_dat_w = wdata;
    n = 0;
    @(negedge clk);
    while (!(wb_ack || wb_err)) begin
      if (n == TIMEOUT) begin
        $display("wishbone port timed out waiting for ack or err at address 0x%0h", a);
        abort_run();
      end
      n++;
      @(negedge clk);
    end
    check_mask({2'b00, wb_err, wb_ack}, {2'b00, exp_err, !exp_err}, "wb err/ack");
    if (!we && !exp_err) check_data(wb_dat_r, shadow[a], "wb read data");
    if (we && !exp_err) shadow[a] = wdata;
    for (int c = 0; c < hold; c++) begin  // master keeps stb up after the answer
      @(negedge clk);
      check_mask({2'b00, wb_err, wb_ack}, '0, "wb err/ack while stb is held");
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic port_read(input step_t s);
    int n;
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) rd_addr[i] = s.addr[i];
    rd_req = s.req;
    n = 0;
    @(negedge clk);
    while (((rd_vld | rd_err) & s.req) != s.req) begin
      if (n == TIMEOUT) begin
        for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
          if (s.req[i] && !(rd_vld[i] || rd_err[i]))
            $display("read port %0d timed out waiting for vld or err", i);
        end
        abort_run();
      end
      n++;
      @(negedge clk);
    end
    check_mask(rd_err, s.err, "read err mask");
    check_mask(rd_vld, s.req & ~s.err, "read vld mask");
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) begin
      if (s.req[i] && !s.err[i])
        check_data(rd_data[i], shadow[s.addr[i]], $sformatf("port %0d read data", i));
    end
    rd_req = '0;
  endtask

  task automatic build_steps();
    mem_cfg_pkg::addr_t fill [9];
    fill = '{7'h03, 7'h09, 7'h15, 7'h1C, 7'h27, 7'h3A, 7'h42, 7'h46, 7'h4F};
    foreach (fill[i]) add_step(OP_WB_WR, 1'b0, fill[i], '0, '0, '0, '0, '0, 4'd0);
    foreach (fill[i]) add_step(OP_WB_RD, 1'b0, fill[i], '0, '0, '0, '0, '0, 4'd0);
    // one port per bank
    add_step(OP_PT_RD, 1'b0, 7'h03, 7'h15, 7'h27, 7'h3A, 4'hF, 4'h0, 4'd0);
    add_step(OP_PT_RD, 1'b0, 7'h42, 7'h09, 7'h1C, 7'h27, 4'hF, 4'h0, 4'd0);
    // lower port wins a shared bank
    add_step(OP_PT_RD, 1'b0, 7'h03, 7'h09, 7'h15, 7'h1C, 4'hF, 4'b1010, 4'd0);
    add_step(OP_PT_RD, 1'b0, 7'h15, 7'h1C, 7'h15, 7'h1C, 4'hF, 4'b1110, 4'd0);
    add_step(OP_PT_RD, 1'b0, 7'h27, 7'h09, 7'h3A, 7'h03, 4'b1010, 4'b1000, 4'd0);
    // 80 and up is always refused and 64 and up is refused in access mode
    add_step(OP_PT_RD, 1'b0, 7'h50, 7'h03, 7'h7F, 7'h15, 4'hF, 4'b0101, 4'd0);
    add_step(OP_WB_WR, 1'b0, 7'h55, '0, '0, '0, '0, 4'h1, 4'd0);
    add_step(OP_WB_RD, 1'b0, 7'h60, '0, '0, '0, '0, 4'h1, 4'd0);
    add_step(OP_PT_RD, 1'b1, 7'h46, '0, '0, '0, 4'h1, 4'h1, 4'd0);
    add_step(OP_WB_WR, 1'b1, 7'h46, '0, '0, '0, '0, 4'h1, 4'd0);
    add_step(OP_WB_RD, 1'b1, 7'h4F, '0, '0, '0, '0, 4'h1, 4'd0);
    add_step(OP_WB_RD, 1'b0, 7'h46, '0, '0, '0, '0, 4'h0, 4'd0);  // still the old word
    add_step(OP_PT_RD, 1'b0, 7'h46, 7'h4F, '0, '0, 4'b0011, 4'b0010, 4'd0);
    add_step(OP_WB_WR, 1'b1, 7'h3A, '0, '0, '0, '0, 4'h0, 4'd0);
    // access mode leaves only port 0
    add_step(OP_PT_RD, 1'b1, 7'h3A, 7'h15, 7'h27, 7'h09, 4'hF, 4'b1110, 4'd0);
    add_step(OP_PT_RD, 1'b1, 7'h03, 7'h15, 7'h27, 7'h09, 4'b0110, 4'b0110, 4'd0);
    // held strobe after the ack
    add_step(OP_WB_WR, 1'b0, 7'h27, '0, '0, '0, '0, 4'h0, 4'd4);
    add_step(OP_WB_RD, 1'b0, 7'h27, '0, '0, '0, '0, 4'h0, 4'd3);
    add_step(OP_PT_RD, 1'b0, 7'h27, 7'h3A, '0, '0, 4'b0011, 4'h0, 4'd0);
  endtask

  // ==============================
  // main sequence

  initial begin
    rd_acc   = 1'b0;
    rd_req   = '0;
    for (int i = 0; i < mem_req_pkg::NUM_RDPT; i++) rd_addr[i] = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    lfsr     = 32'h22dd;
    build_steps();
    wait_reset();
    check_mask(rd_vld, '0, "rd_vld after reset");
    check_mask(rd_err, '0, "rd_err after reset");
    check_mask({2'b00, wb_err, wb_ack}, '0, "wb err/ack after reset");
    foreach (steps[i]) begin
      @(negedge clk);
      rd_acc = steps[i].acc;
      case (steps[i].op)
        OP_WB_WR: wb_cycle(1'b1, steps[i].addr[0], steps[i].err[0], int'(steps[i].hold));
        OP_WB_RD: wb_cycle(1'b0, steps[i].addr[0], steps[i].err[0], int'(steps[i].hold));
        default:  port_read(steps[i]);
      endcase
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hw/mem_cfg_pkg.sv
hw/mem_req_pkg.sv
hw/mem_rd_if.sv
hw/read_port_guard.sv
hw/bank_array.sv
hw/wb_rw_port.sv
hw/multiport_mem.sv
tests/tb_clock_gen.sv
tests/tb_multiport_mem.sv

/* run_sim.sh */
#!/bin/sh
# builds the multiport memory testbench with Verilator and runs it
# the exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_multiport_mem -f sources.f \
  -Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
